/* include/cnn_defs.svh */
`ifndef CNN_DEFS_SVH
`define CNN_DEFS_SVH

//------------------------------
// tile geometry
`define TILE_W          8
`define TILE_H          8
`define TILE_PIXELS     (`TILE_W * `TILE_H)
`define TILE_ADDR_W     6

//------------------------------
// datapath sizes
`define KERNEL_TAPS     9           // 3x3 window
`define NUM_FEATURES    4           // one per quadrant
`define POOL_SHIFT      4           // 16 results per quadrant

//------------------------------
// configuration map
`define CFG_ADDR_W      4
`define CFG_BIAS_ADDR   13          // kernel 0-8, fc weights 9-12

`endif

/* rtl/cnnPkg.sv */
`default_nettype none
`include "cnn_defs.svh"

package cnnPkg;

    typedef logic [7:0]        pixel_t;            // grey value, first byte of pair
    typedef logic signed [7:0] coeff_t;
    typedef coeff_t [`KERNEL_TAPS-1:0] kernel_t;   // tap 0 top-left, row-major

    typedef logic [15:0] convOut_t;                // after relu and clipping
    typedef logic [15:0] feature_t;
    typedef feature_t [`NUM_FEATURES-1:0] featureVec_t;  // 0 tl, 1 tr, 2 bl, 3 br

    typedef struct packed {
        coeff_t [`NUM_FEATURES-1:0] weight;
        logic signed [15:0]         bias;
    } fcCfg_t;

    typedef logic signed [31:0] score_t;

    typedef struct packed {
        logic       vsync;
        logic       href;
        logic [7:0] data;
    } camBus_t;

    typedef struct packed {
        logic                    wr;
        logic [`TILE_ADDR_W-1:0] addr;
        pixel_t                  data;
    } pixWr_t;

endpackage

`default_nettype wire

/* rtl/camCapture.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cnn_defs.svh"

module camCapture
    import cnnPkg::*;
(
    input  wire          i_clk100,
    input  wire          i_rstN,
    input  wire camBus_t i_cam,
    input  wire          i_arm,
    output pixWr_t       o_pixWr,
    output logic         o_frameDone
);
    logic                    armed;
    logic                    inFrame;      // vsync seen since arm
    logic                    phase;        // 1 on second byte of a pair
    logic [`TILE_ADDR_W-1:0] wrAddr;
    pixel_t                  firstByte;
    logic                    takeByte;

    assign takeByte = armed && inFrame && i_cam.href;

    always_ff @(posedge i_clk100 or negedge i_rstN) begin
        if (!i_rstN) begin
            armed       <= 1'b0;
            inFrame     <= 1'b0;
            phase       <= 1'b0;
            wrAddr      <= '0;
            o_pixWr     <= '0;
            o_frameDone <= 1'b0;
        end else begin
            o_pixWr.wr  <= 1'b0;
            o_frameDone <= 1'b0;
            if (i_arm) begin
                armed   <= 1'b1;
                inFrame <= 1'b0;
                phase   <= 1'b0;
                wrAddr  <= '0;
            end else if (armed && !inFrame) begin
                inFrame <= i_cam.vsync;                  // frame starts after vsync
            end else if (takeByte) begin
                phase <= ~phase;
                if (phase) begin                         // pair complete
                    o_pixWr.wr   <= 1'b1;
                    o_pixWr.addr <= wrAddr;
                    o_pixWr.data <= firstByte;
                    wrAddr       <= wrAddr + 1'b1;
                    if (wrAddr == (`TILE_PIXELS - 1)) begin
                        armed       <= 1'b0;             // tile full
                        o_frameDone <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge i_clk100) begin
        if (takeByte && !phase)
            firstByte <= i_cam.data;                     // keep grey byte
    end

    // a finished tile stays untouched until capture is armed again
    assert property (@(posedge i_clk100) disable iff (!i_rstN)
        o_frameDone |=> (!o_pixWr.wr until i_arm))
        else $error("camCapture: pixel write after full tile");

endmodule

`default_nettype wire

/* rtl/tileRam.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cnn_defs.svh"

module tileRam
    import cnnPkg::*;
(
    input  wire                    i_clk100,
    input  wire pixWr_t            i_pixWr,
    input  wire [`TILE_ADDR_W-1:0] i_rdAddr,
    output pixel_t                 o_rdData
);
    pixel_t mem [`TILE_PIXELS];

    always_ff @(posedge i_clk100) begin
        if (i_pixWr.wr)
            mem[i_pixWr.addr] <= i_pixWr.data;
        o_rdData <= mem[i_rdAddr];                       // one cycle read latency
    end

endmodule

`default_nettype wire

/* rtl/convEngine.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cnn_defs.svh"

module convEngine
    import cnnPkg::*;
(
    input  wire                      i_clk100,
    input  wire                      i_rstN,
    input  wire                      i_start,
    input  wire kernel_t             i_kernel,
    input  wire pixel_t              i_rdData,
    output logic [`TILE_ADDR_W-1:0]  o_rdAddr,
    output logic                     o_resValid,
    output logic [`TILE_ADDR_W-1:0]  o_resPos,
    output convOut_t                 o_res,
    output logic                     o_done
);
    localparam logic [3:0] LAST_PHASE = 4'd9;            // result cycle after 9 taps

    logic                    running;
    logic [`TILE_ADDR_W-1:0] pos;
    logic [3:0]              phase;
    logic                    active;
    logic                    lastPhase;
    logic [1:0]              tapRow;
    logic [1:0]              tapCol;
    logic [4:0]              nRow;
    logic [4:0]              nCol;
    logic                    padded;
    logic                    accEn;
    logic                    tapPad;
    coeff_t                  tapW;
    logic signed [16:0]      product;
    logic signed [19:0]      acc;
    logic signed [19:0]      sum;
    convOut_t                clipped;

    assign active    = running || i_start;               // start cycle is tap 0 of pos 0
    assign lastPhase = running && (phase == LAST_PHASE);

    //------------------------------
    // neighbour address and padding
    always_comb begin
        tapRow = 2'(phase / 4'd3);
        tapCol = 2'(phase % 4'd3);
        nRow   = {2'b00, pos[5:3]} + {3'b000, tapRow} - 5'd1;   // -1..8
        nCol   = {2'b00, pos[2:0]} + {3'b000, tapCol} - 5'd1;
    end

    assign padded   = nRow[4] | nRow[3] | nCol[4] | nCol[3];   // outside the tile
    assign o_rdAddr = {nRow[2:0], nCol[2:0]};

    //------------------------------
    // multiply-accumulate
    assign product = $signed({1'b0, i_rdData}) * tapW;
    assign sum     = acc + ((accEn && !tapPad) ? 20'(product) : 20'sd0);

    always_comb begin
        if (sum[19])
            clipped = '0;                                // relu
        else if (|sum[18:16])
            clipped = 16'hFFFF;                          // saturate
        else
            clipped = sum[15:0];
    end

    always_ff @(posedge i_clk100 or negedge i_rstN) begin
        if (!i_rstN) begin
            running    <= 1'b0;
            pos        <= '0;
            phase      <= '0;
            accEn      <= 1'b0;
            acc        <= '0;
            o_resValid <= 1'b0;
            o_done     <= 1'b0;
        end else begin
            accEn      <= active && (phase != LAST_PHASE);
            o_resValid <= lastPhase;
            o_done     <= lastPhase && (pos == (`TILE_PIXELS - 1));
            if (i_start)
                running <= 1'b1;
            if (active) begin
                if (phase == LAST_PHASE) begin
                    phase <= '0;
                    pos   <= pos + 1'b1;
                    acc   <= '0;                         // fresh sum per position
                    if (pos == (`TILE_PIXELS - 1))
                        running <= 1'b0;
                end else begin
                    phase <= phase + 1'b1;
                    acc   <= sum;
                end
            end
        end
    end

    always_ff @(posedge i_clk100) begin
        if (active && (phase != LAST_PHASE)) begin
            tapPad <= padded;                            // used with next cycle's data
            tapW   <= i_kernel[phase];
        end
        if (lastPhase) begin
            o_res    <= clipped;
            o_resPos <= pos;
        end
    end

    // sequencer must not restart the engine mid-tile
    assert property (@(posedge i_clk100) disable iff (!i_rstN)
        i_start |-> !running)
        else $error("convEngine: start while running");

endmodule

`default_nettype wire

/* rtl/poolAverage.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cnn_defs.svh"

module poolAverage
    import cnnPkg::*;
(
    input  wire                    i_clk100,
    input  wire                    i_rstN,
    input  wire                    i_clear,
    input  wire                    i_resValid,
    input  wire [`TILE_ADDR_W-1:0] i_resPos,
    input  wire convOut_t          i_res,
    output featureVec_t            o_features
);
    logic [19:0] sums [`NUM_FEATURES];
    logic [1:0]  quad;

    assign quad = {i_resPos[5], i_resPos[2]};            // row bit 2, col bit 2

    always_ff @(posedge i_clk100 or negedge i_rstN) begin
        if (!i_rstN) begin
            for (int q = 0; q < `NUM_FEATURES; q++)
                sums[q] <= '0;
        end else if (i_clear) begin
            for (int q = 0; q < `NUM_FEATURES; q++)
                sums[q] <= '0;                           // new tile
        end else if (i_resValid) begin
            sums[quad] <= sums[quad] + 20'(i_res);
        end
    end

    // average of 16 results, truncated
    always_comb begin
        for (int q = 0; q < `NUM_FEATURES; q++)
            o_features[q] = feature_t'(sums[q] >> `POOL_SHIFT);
    end

endmodule

`default_nettype wire

/* rtl/fullyConnected.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cnn_defs.svh"

module fullyConnected
    import cnnPkg::*;
(
    input  wire              i_clk100,
    input  wire              i_rstN,
    input  wire              i_start,
    input  wire featureVec_t i_features,
    input  wire fcCfg_t      i_fc,
    output score_t           o_score,
    output logic             o_led,
    output logic             o_done
);
    logic               running;
    logic [1:0]         idx;                             // feature being added
    score_t             acc;
    score_t             sum;
    logic signed [24:0] product;

    assign product = $signed(i_fc.weight[idx]) * $signed({1'b0, i_features[idx]});
    assign sum     = acc + product;

    always_ff @(posedge i_clk100 or negedge i_rstN) begin
        if (!i_rstN) begin
            running <= 1'b0;
            idx     <= '0;
            acc     <= '0;
            o_score <= '0;
            o_led   <= 1'b0;
            o_done  <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                running <= 1'b1;
                idx     <= '0;
                acc     <= score_t'(i_fc.bias);          // sign-extended bias
            end else if (running) begin
                idx <= idx + 1'b1;
                acc <= sum;
                if (idx == 2'd3) begin
                    running <= 1'b0;
                    o_score <= sum;
                    o_led   <= sum[31];                  // sign drives the led
                    o_done  <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/weightRegs.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cnn_defs.svh"

module weightRegs
    import cnnPkg::*;
(
    input  wire                   i_clk100,
    input  wire                   i_rstN,
    input  wire                   i_cfgWr,
    input  wire [`CFG_ADDR_W-1:0] i_cfgAddr,
    input  wire [15:0]            i_cfgData,
    output kernel_t               o_kernel,
    output fcCfg_t                o_fc
);
    logic [1:0] fcIdx;

    assign fcIdx = 2'(i_cfgAddr - `KERNEL_TAPS);         // fc weights follow the kernel

    always_ff @(posedge i_clk100 or negedge i_rstN) begin
        if (!i_rstN) begin
            o_kernel <= '0;
            o_fc     <= '0;
        end else if (i_cfgWr) begin
            if (i_cfgAddr < `KERNEL_TAPS)
                o_kernel[i_cfgAddr] <= coeff_t'(i_cfgData[7:0]);
            else if (i_cfgAddr < `CFG_BIAS_ADDR)
                o_fc.weight[fcIdx] <= coeff_t'(i_cfgData[7:0]);
            else if (i_cfgAddr == `CFG_BIAS_ADDR)
                o_fc.bias <= i_cfgData;
            // anything above the bias is dropped
        end
    end

endmodule

`default_nettype wire

/* rtl/masterControl.sv */
`timescale 1ns/10ps
`default_nettype none

module masterControl (
    input  wire  i_clk100,
    input  wire  i_rstN,
    input  wire  i_start,
    input  wire  i_frameDone,
    input  wire  i_convDone,
    input  wire  i_fcDone,
    output logic o_arm,
    output logic o_convStart,
    output logic o_fcStart,
    output logic o_busy,
    output logic o_done
);
    typedef enum logic [2:0] {IDLE, CAPTURE, CONV, SETTLE, SCORE} state_t;

    state_t state;

    always_ff @(posedge i_clk100 or negedge i_rstN) begin
        if (!i_rstN) begin
            state       <= IDLE;
            o_arm       <= 1'b0;
            o_convStart <= 1'b0;
            o_fcStart   <= 1'b0;
        end else begin
            o_arm       <= 1'b0;
            o_convStart <= 1'b0;
            o_fcStart   <= 1'b0;
            case (state)
                IDLE: if (i_start) begin                 // start ignored elsewhere
                    state <= CAPTURE;
                    o_arm <= 1'b1;
                end
                CAPTURE: if (i_frameDone) begin
                    state       <= CONV;
                    o_convStart <= 1'b1;
                end
                CONV: if (i_convDone)
                    state <= SETTLE;
                SETTLE: begin                            // let last feature land
                    state     <= SCORE;
                    o_fcStart <= 1'b1;
                end
                SCORE: if (i_fcDone)
                    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    assign o_busy = (state != IDLE);
    assign o_done = (state == SCORE) && i_fcDone;        // same cycle as new score

    // each stage reports back only while it is the active one
    assert property (@(posedge i_clk100) disable iff (!i_rstN)
        (!i_frameDone || state == CAPTURE) && (!i_convDone || state == CONV) &&
        (!i_fcDone || state == SCORE))
        else $error("masterControl: stage done outside its state");

endmodule

`default_nettype wire

/* rtl/classifierTop.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cnn_defs.svh"

module classifierTop
    import cnnPkg::*;
(
    input  wire                   i_clk100,
    input  wire                   i_rstN,
    input  wire camBus_t          i_cam,
    input  wire                   i_start,
    input  wire                   i_cfgWr,
    input  wire [`CFG_ADDR_W-1:0] i_cfgAddr,
    input  wire [15:0]            i_cfgData,
    output logic                  o_busy,
    output logic                  o_done,
    output score_t                o_score,
    output logic                  o_led
);
    pixWr_t                  pixWr;
    pixel_t                  rdData;
    logic [`TILE_ADDR_W-1:0] rdAddr;
    logic [`TILE_ADDR_W-1:0] resPos;
    logic                    resValid;
    convOut_t                res;
    featureVec_t             features;
    kernel_t                 kernel;
    fcCfg_t                  fcCfg;
    logic                    arm, frameDone;
    logic                    convStart, convDone;
    logic                    fcStart, fcDone;

    //------------------------------
    camCapture camCaptureBlock (
        .i_clk100(i_clk100),
        .i_rstN(i_rstN),
        .i_cam(i_cam),
        .i_arm(arm),
        .o_pixWr(pixWr),
        .o_frameDone(frameDone)
    );

    tileRam tileRamBlock (
        .i_clk100(i_clk100),
        .i_pixWr(pixWr),
        .i_rdAddr(rdAddr),
        .o_rdData(rdData)
    );

    //------------------------------
    convEngine convEngineBlock (
        .i_clk100(i_clk100),
        .i_rstN(i_rstN),
        .i_start(convStart),
        .i_kernel(kernel),
        .i_rdData(rdData),
        .o_rdAddr(rdAddr),
        .o_resValid(resValid),
        .o_resPos(resPos),
        .o_res(res),
        .o_done(convDone)
    );

    poolAverage poolAverageBlock (
        .i_clk100(i_clk100),
        .i_rstN(i_rstN),
        .i_clear(convStart),                             // sums restart with each tile
        .i_resValid(resValid),
        .i_resPos(resPos),
        .i_res(res),
        .o_features(features)
    );

    fullyConnected fullyConnectedBlock (
        .i_clk100(i_clk100),
        .i_rstN(i_rstN),
        .i_start(fcStart),
        .i_features(features),
        .i_fc(fcCfg),
        .o_score(o_score),
        .o_led(o_led),
        .o_done(fcDone)
    );

    //------------------------------
    weightRegs weightRegsBlock (
        .i_clk100(i_clk100),
        .i_rstN(i_rstN),
        .i_cfgWr(i_cfgWr),
        .i_cfgAddr(i_cfgAddr),
        .i_cfgData(i_cfgData),
        .o_kernel(kernel),
        .o_fc(fcCfg)
    );

    masterControl masterControlBlock (
        .i_clk100(i_clk100),
        .i_rstN(i_rstN),
        .i_start(i_start),
        .i_frameDone(frameDone),
        .i_convDone(convDone),
        .i_fcDone(fcDone),
        .o_arm(arm),
        .o_convStart(convStart),
        .o_fcStart(fcStart),
        .o_busy(o_busy),
        .o_done(o_done)
    );

endmodule

`default_nettype wire

/* tests/tb_classifierTop.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cnn_defs.svh"

module tb_classifierTop
    import cnnPkg::*;
();
    logic                   clk;
    logic                   rstN;
    camBus_t                cam;
    logic                   start;
    logic                   cfgWr;
    logic [`CFG_ADDR_W-1:0] cfgAddr;
    logic [15:0]            cfgData;
    logic                   busy;
    logic                   done;
    score_t                 score;
    logic                   led;

    int pix [`TILE_PIXELS];                              // grey values of the tile
    int kern [`KERNEL_TAPS];
    int fcW [`NUM_FEATURES];
    int bias;
    int seed;

    classifierTop classifierTop_inst (
        .i_clk100(clk),
        .i_rstN(rstN),
        .i_cam(cam),
        .i_start(start),
        .i_cfgWr(cfgWr),
        .i_cfgAddr(cfgAddr),
        .i_cfgData(cfgData),
        .o_busy(busy),
        .o_done(done),
        .o_score(score),
        .o_led(led)
    );

    always #5 clk = ~clk;                                // 100 MHz

    //------------------------------
    // reference model
    function automatic int convAt(int r, int c);
        int acc;
        int nr;
        int nc;
        acc = 0;
        for (int kr = 0; kr < 3; kr++) begin
            for (int kc = 0; kc < 3; kc++) begin
                nr = r + kr - 1;
                nc = c + kc - 1;
                if (nr >= 0 && nr < `TILE_H && nc >= 0 && nc < `TILE_W)
                    acc += kern[kr * 3 + kc] * pix[nr * `TILE_W + nc];   // zero padding
            end
        end
        if (acc < 0)
            acc = 0;
        else if (acc > 65535)
            acc = 65535;
        return acc;
    endfunction

    function automatic int featureOf(int q);
        int sum;
        sum = 0;
        for (int r = 0; r < `TILE_H; r++)
            for (int c = 0; c < `TILE_W; c++)
                if ((r >= 4) == q[1] && (c >= 4) == q[0])
                    sum += convAt(r, c);
        return sum / 16;                                 // 16 results per quadrant
    endfunction

    function automatic int modelScore();
        int s;
        s = bias;
        for (int q = 0; q < `NUM_FEATURES; q++)
            s += fcW[q] * featureOf(q);
        return s;
    endfunction

    //------------------------------
    // drivers and checks
    task automatic nextCycle();
        @(posedge clk);
        #1;                                              // drive and sample after the edge
    endtask

    task automatic checkValue(input string testName, input int expected, input int actual);
        if (expected != actual) begin
            $display("error: %s expected %0d actual %0d", testName, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic writeCfg(input int addr, input int data);
        cfgWr   = 1'b1;
        cfgAddr = addr[`CFG_ADDR_W-1:0];
        cfgData = data[15:0];
        nextCycle();
        cfgWr   = 1'b0;
    endtask

    task automatic loadConfig();
        for (int t = 0; t < `KERNEL_TAPS; t++)
            writeCfg(t, kern[t] & 8'hFF);
        for (int w = 0; w < `NUM_FEATURES; w++)
            writeCfg(`KERNEL_TAPS + w, fcW[w] & 8'hFF);
        writeCfg(`CFG_BIAS_ADDR, bias & 16'hFFFF);
        writeCfg(15, 16'h5A5A);                          // unmapped address is dropped
    endtask

    task automatic sendFrame();
        cam.vsync = 1'b1;
        cam.href  = 1'b0;
        cam.data  = 8'($random(seed));
        nextCycle();
        cam.vsync = 1'b0;
        for (int r = 0; r < `TILE_H; r++) begin
            for (int b = 0; b < 2 * `TILE_W; b++) begin
                cam.href = 1'b1;
                if (b % 2 == 0)
                    cam.data = 8'(pix[r * `TILE_W + b / 2]);
                else
                    cam.data = 8'($random(seed));        // second byte is dropped
                nextCycle();
            end
            for (int g = 0; g < 3; g++) begin
                cam.href = 1'b0;
                cam.data = 8'($random(seed));            // stray bytes between lines
                nextCycle();
            end
        end
        cam = '0;
    endtask

    task automatic waitDone(input string testName);
        int cycles;
        cycles = 0;
        while (!done) begin
            nextCycle();
            cycles++;
            if (cycles > 3000) begin
                $display("%s: timed out waiting for the done pulse", testName);
                $display("TEST RESULT: FAIL");
                $fatal(1);
            end
        end
    endtask

    task automatic runTile(input string testName, input bit strayStart);
        int expected;
        expected = modelScore();
        checkValue({testName, " idle before start"}, 0, busy);
        start = 1'b1;
        nextCycle();
        start = 1'b0;
        checkValue({testName, " busy after start"}, 1, busy);
        nextCycle();
        nextCycle();                                     // capture armed by now
        sendFrame();
        if (strayStart) begin
            nextCycle();
            start = 1'b1;                                // lands during convolution
            nextCycle();
            start = 1'b0;
        end
        waitDone(testName);
        checkValue({testName, " score"}, expected, score);
        checkValue({testName, " led"}, (expected < 0) ? 1 : 0, led);
        for (int i = 0; i < 4; i++) begin
            nextCycle();
            checkValue({testName, " done pulse"}, 0, done);
            checkValue({testName, " busy after done"}, 0, busy);
            checkValue({testName, " score held"}, expected, score);
            checkValue({testName, " led held"}, (expected < 0) ? 1 : 0, led);
        end
    endtask

    task automatic fillRandom();
        for (int p = 0; p < `TILE_PIXELS; p++)
            pix[p] = $random(seed) & 8'hFF;
        for (int t = 0; t < `KERNEL_TAPS; t++)
            kern[t] = $random(seed) % 128;
        for (int w = 0; w < `NUM_FEATURES; w++)
            fcW[w] = $random(seed) % 128;
        bias = $random(seed) % 32768;
    endtask

    //------------------------------
    // directed tests
    task automatic testReset();
        checkValue("reset busy", 0, busy);
        checkValue("reset done", 0, done);
        checkValue("reset led", 0, led);
        checkValue("reset score", 0, score);
    endtask

    task automatic testIdentity();
        int avg;
        fillRandom();
        kern = '{0, 0, 0, 0, 1, 0, 0, 0, 0};
        fcW  = '{1, 0, 0, 0};
        bias = 0;
        loadConfig();
        avg = 0;
        for (int r = 0; r < 4; r++)
            for (int c = 0; c < 4; c++)
                avg += pix[r * `TILE_W + c];
        runTile("identity kernel", 1'b0);
        checkValue("identity average", avg / 16, score);
    endtask

    task automatic testPadding();
        for (int p = 0; p < `TILE_PIXELS; p++)
            pix[p] = 10;
        kern = '{1, 1, 1, 1, 1, 1, 1, 1, 1};
        fcW  = '{1, 2, -3, 4};
        bias = 5;
        loadConfig();
        runTile("zero padding", 1'b0);
    endtask

    task automatic testRelu();
        fillRandom();
        kern = '{-1, -1, -1, -1, -1, -1, -1, -1, -1};    // no window sum above zero
        bias = 77;
        loadConfig();
        runTile("relu positive bias", 1'b0);
        checkValue("relu positive bias direct", 77, score);
        bias = -300;
        loadConfig();
        runTile("relu negative bias", 1'b0);
        checkValue("relu negative bias direct", -300, score);
        checkValue("relu negative bias led", 1, led);
    endtask

    task automatic testRandom();
        fillRandom();
        loadConfig();
        runTile("random tile", 1'b0);
    endtask

    task automatic testBackToBack();
        fillRandom();
        loadConfig();
        runTile("back to back first", 1'b1);
        fillRandom();
        kern[4] = 127;                                   // config change between runs
        loadConfig();
        runTile("back to back second", 1'b0);
    endtask

    initial begin
        seed    = 32'h640f;
        clk     = 1'b0;
        rstN    = 1'b0;
        cam     = '0;
        start   = 1'b0;
        cfgWr   = 1'b0;
        cfgAddr = '0;
        cfgData = '0;
        bias    = 0;
        repeat (2) @(posedge clk);
        #1;
        rstN = 1'b1;
        testReset();
        nextCycle();
        testIdentity();
        testPadding();
        testRelu();
        testRandom();
        testBackToBack();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+include
rtl/cnnPkg.sv
rtl/camCapture.sv
rtl/tileRam.sv
rtl/convEngine.sv
rtl/poolAverage.sv
rtl/fullyConnected.sv
rtl/weightRegs.sv
rtl/masterControl.sv
rtl/classifierTop.sv
tests/tb_classifierTop.sv

/* Bender.yml */
package:
  name: cnn_classifier

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/cnnPkg.sv
      - rtl/camCapture.sv
      - rtl/tileRam.sv
      - rtl/convEngine.sv
      - rtl/poolAverage.sv
      - rtl/fullyConnected.sv
      - rtl/weightRegs.sv
      - rtl/masterControl.sv
      - rtl/classifierTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_classifierTop.sv
